// File: pkt_core_array.f
pkt_pkg.sv
pkt_dispatch.sv
core_slot_unit.sv
egress_arb.sv
pkt_core_array.sv
tb_pkt_core_array.sv

// File: Makefile
# Verilator build and run for the packet core array
# Override any variable on the command line, e.g. make LOG=run2.log

VERILATOR  ?= verilator
TB_TOP     ?= tb_pkt_core_array
RTL_TOP    ?= pkt_core_array
FILELIST   ?= pkt_core_array.f
RTL_SRCS   ?= pkt_pkg.sv pkt_dispatch.sv core_slot_unit.sv egress_arb.sv pkt_core_array.sv
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Testbench passed
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_pkt_core_array.sv
`timescale 1ns/1ps
/*
 * Testbench for the packet core array. Sends random tagged frames on both
 * ingress ports, toggles egress ready at random and checks every received
 * frame against its stored copy, including the port swap and reset state.
 */
module tb_pkt_core_array;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 16;
  localparam int FRAME_COUNT    = 200;
  localparam int TIMEOUT_CYCLES = FRAME_COUNT * (pkt_pkg::MAX_BEATS + 20);

  logic                           clk;
  logic                           reset;
  logic [pkt_pkg::PORT_COUNT-1:0] in_valid;
  pkt_pkg::beat_t                 in_beat [pkt_pkg::PORT_COUNT];
  logic [pkt_pkg::PORT_COUNT-1:0] in_ready;
  logic [pkt_pkg::PORT_COUNT-1:0] out_valid;
  pkt_pkg::beat_t                 out_beat [pkt_pkg::PORT_COUNT];
  logic [pkt_pkg::PORT_COUNT-1:0] out_ready;

  integer seed;
  int     cycle_count;

  // Stored frames, indexed by frame number
  pkt_pkg::beat_t frame_mem [FRAME_COUNT][pkt_pkg::MAX_BEATS];
  int             frame_len [FRAME_COUNT];
  int             gap_len [FRAME_COUNT];
  bit             seen [FRAME_COUNT];
  int             rx_count;

  // Sender and receiver state per port
  int          tx_frame [pkt_pkg::PORT_COUNT];
  int          tx_beat [pkt_pkg::PORT_COUNT];
  int          tx_gap [pkt_pkg::PORT_COUNT];
  logic [31:0] rx_frame [pkt_pkg::PORT_COUNT];
  int          rx_beat [pkt_pkg::PORT_COUNT];

  pkt_core_array i_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  // Frame number in the upper word of beat 0, ingress port in bit 0
  task automatic build_frames();
    logic [pkt_pkg::DATA_WIDTH-1:0] word;
    logic [pkt_pkg::KEEP_WIDTH-1:0] keep;
    for (int f = 0; f < FRAME_COUNT; f++) begin
      frame_len[f] = 1 + int'($unsigned($random(seed)) % pkt_pkg::MAX_BEATS);
      gap_len[f]   = int'($unsigned($random(seed)) % 4);
      seen[f]      = 1'b0;
      for (int b = 0; b < frame_len[f]; b++) begin
        word = {$random(seed), $random(seed)};
        keep = '1;
        if (b == 0) begin
          word[63:32] = f;
          word[0]     = f % pkt_pkg::PORT_COUNT;
        end
        if (b == frame_len[f] - 1) begin
          keep = 8'hFF >> ($unsigned($random(seed)) % pkt_pkg::KEEP_WIDTH);
        end
        frame_mem[f][b] = '{data: word, keep: keep, last: (b == frame_len[f] - 1)};
      end
    end
  endtask

  function automatic bit all_seen();
    bit ok;
    ok = 1'b1;
    for (int f = 0; f < FRAME_COUNT; f++) begin
      ok = ok && seen[f];
    end
    return ok;
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    seed      = 8380;
    rx_count  = 0;
    reset     = 1'b1;
    in_valid  = '0;
    out_ready = '0;
    build_frames();
    for (int p = 0; p < pkt_pkg::PORT_COUNT; p++) begin
      in_beat[p]  = '0;
      tx_frame[p] = p;
      tx_beat[p]  = 0;
      tx_gap[p]   = 0;
      rx_frame[p] = '0;
      rx_beat[p]  = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

  // Ingress: port p sends frames p, p+2, p+4 ...
  always @(posedge clk) begin
    if (reset) begin
      // First beat of each port already waits on the bus through reset
      for (int p = 0; p < pkt_pkg::PORT_COUNT; p++) begin
        in_valid[p] <= 1'b1;
        in_beat[p]  <= frame_mem[tx_frame[p]][0];
      end
    end else begin
      for (int p = 0; p < pkt_pkg::PORT_COUNT; p++) begin
        if (in_valid[p] && in_ready[p]) begin
          if (tx_beat[p] == frame_len[tx_frame[p]] - 1) begin
            tx_frame[p] = tx_frame[p] + pkt_pkg::PORT_COUNT;
            tx_beat[p]  = 0;
            if (tx_frame[p] < FRAME_COUNT) begin
              tx_gap[p] = gap_len[tx_frame[p]];
            end
          end else begin
            tx_beat[p] = tx_beat[p] + 1;
          end
        end
        if (tx_frame[p] >= FRAME_COUNT) begin
          in_valid[p] <= 1'b0;
        end else if (tx_gap[p] > 0) begin
          in_valid[p] <= 1'b0;
          tx_gap[p] = tx_gap[p] - 1;
        end else begin
          in_valid[p] <= 1'b1;
          in_beat[p]  <= frame_mem[tx_frame[p]][tx_beat[p]];
        end
      end
    end
  end

  // Egress scoreboard and random back-pressure
  always @(posedge clk) begin
    pkt_pkg::beat_t exp_beat;
    logic [31:0]    fn_word;
    if (reset) begin
      out_ready <= '0;
    end else begin
      for (int q = 0; q < pkt_pkg::PORT_COUNT; q++) begin
        if (out_valid[q] && out_ready[q]) begin
          if (rx_beat[q] == 0) begin
            fn_word = out_beat[q].data[63:32];
            assert (fn_word < FRAME_COUNT)
              else fail_run($sformatf("Unknown frame number %0d arrived on port %0d", fn_word, q));
            assert (!seen[fn_word])
              else fail_run($sformatf("Frame %0d arrived a second time", fn_word));
            // Frame from port p must leave on port 1-p
            assert (q == 1 - (int'(fn_word) % pkt_pkg::PORT_COUNT))
              else fail_run($sformatf("Mismatch egress port of frame %0d: expected %h, got %h",
                fn_word, 1 - (int'(fn_word) % pkt_pkg::PORT_COUNT), q));
            rx_frame[q] = fn_word;
          end
          exp_beat = frame_mem[rx_frame[q]][rx_beat[q]];
          assert (out_beat[q].data == exp_beat.data)
            else fail_run($sformatf("Mismatch out_beat[%0d].data: expected %h, got %h",
              q, exp_beat.data, out_beat[q].data));
          assert (out_beat[q].keep == exp_beat.keep)
            else fail_run($sformatf("Mismatch out_beat[%0d].keep: expected %h, got %h",
              q, exp_beat.keep, out_beat[q].keep));
          assert (out_beat[q].last == exp_beat.last)
            else fail_run($sformatf("Mismatch out_beat[%0d].last: expected %h, got %h",
              q, exp_beat.last, out_beat[q].last));
          if (out_beat[q].last) begin
            seen[rx_frame[q]] = 1'b1;
            rx_count          = rx_count + 1;
            rx_beat[q]        = 0;
          end else begin
            rx_beat[q] = rx_beat[q] + 1;
          end
        end
        out_ready[q] <= ($unsigned($random(seed)) % 4) != 0;
      end
    end
  end

  // Nothing valid or ready while reset holds, once the first edge has passed
  a_reset_quiet: assert property (@(posedge clk)
    (reset && cycle_count > 0) |-> (out_valid == '0 && in_ready == '0))
    else fail_run($sformatf("Mismatch out_valid/in_ready during reset: expected 0/0, got %h/%h",
      $sampled(out_valid), $sampled(in_ready)));

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout after %0d cycles with %0d of %0d frames received",
        cycle_count, rx_count, FRAME_COUNT));
    end
  end

  initial begin
    cycle_count = 0;
    wait (rx_count == FRAME_COUNT);
    repeat (4) @(posedge clk);
    if (rx_count == FRAME_COUNT && all_seen()) begin
      $display("Testbench passed");
      $finish;
    end else begin
      fail_run("Some frames were missing or arrived more than once at the end of the run");
    end
  end

endmodule

// File: pkt_core_array.sv
`timescale 1ns/1ps
/*
 * Top level of the packet path. Ingress streams go through the dispatcher
 * into a row of identical slot cores, and the egress arbiter drains the
 * cores onto the two egress streams with ports swapped.
 */
module pkt_core_array (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [pkt_pkg::PORT_COUNT-1:0] in_valid,
  input  pkt_pkg::beat_t                 in_beat [pkt_pkg::PORT_COUNT],
  output logic [pkt_pkg::PORT_COUNT-1:0] in_ready,
  output logic [pkt_pkg::PORT_COUNT-1:0] out_valid,
  output pkt_pkg::beat_t                 out_beat [pkt_pkg::PORT_COUNT],
  input  logic [pkt_pkg::PORT_COUNT-1:0] out_ready
);

  // Dispatcher to cores, one shared beat bus
  logic [pkt_pkg::CORE_COUNT-1:0] core_in_valid;
  pkt_pkg::routed_beat_t          core_in_beat;
  logic [pkt_pkg::CORE_COUNT-1:0] core_in_ready;
  logic [pkt_pkg::CORE_COUNT-1:0] slot_free;

  // Cores to arbiter
  logic [pkt_pkg::CORE_COUNT-1:0] core_out_valid;
  pkt_pkg::routed_beat_t          core_out_beat [pkt_pkg::CORE_COUNT];
  logic [pkt_pkg::CORE_COUNT-1:0] core_out_ready;

  pkt_dispatch i_dispatch (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .in_beat       (in_beat),
    .in_ready      (in_ready),
    .core_in_valid (core_in_valid),
    .core_in_beat  (core_in_beat),
    .core_in_ready (core_in_ready),
    .slot_free     (slot_free)
  );

  for (genvar c = 0; c < pkt_pkg::CORE_COUNT; c++) begin : g_core
    core_slot_unit i_core (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (core_in_valid[c]),
      .in_beat   (core_in_beat),
      .in_ready  (core_in_ready[c]),
      .out_valid (core_out_valid[c]),
      .out_beat  (core_out_beat[c]),
      .out_ready (core_out_ready[c]),
      .slot_free (slot_free[c])
    );
  end

  egress_arb i_egress (
    .clk            (clk),
    .reset          (reset),
    .core_out_valid (core_out_valid),
    .core_out_beat  (core_out_beat),
    .core_out_ready (core_out_ready),
    .out_valid      (out_valid),
    .out_beat       (out_beat),
    .out_ready      (out_ready)
  );

endmodule

// File: egress_arb.sv
`timescale 1ns/1ps
/*
 * Egress arbiter. Each egress port grants one core round-robin among those
 * whose pending beat names that port and keeps the grant until the last
 * beat is taken. Paths from core to port are combinational.
 */
module egress_arb (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [pkt_pkg::CORE_COUNT-1:0] core_out_valid,
  input  pkt_pkg::routed_beat_t          core_out_beat [pkt_pkg::CORE_COUNT],
  output logic [pkt_pkg::CORE_COUNT-1:0] core_out_ready,
  output logic [pkt_pkg::PORT_COUNT-1:0] out_valid,
  output pkt_pkg::beat_t                 out_beat [pkt_pkg::PORT_COUNT],
  input  logic [pkt_pkg::PORT_COUNT-1:0] out_ready
);

  // Ready contribution of each egress port
  logic [pkt_pkg::CORE_COUNT-1:0] ready_mask [pkt_pkg::PORT_COUNT];

  // First requester after the previous winner
  function automatic pkt_pkg::core_id_t rr_pick(
    logic [pkt_pkg::CORE_COUNT-1:0] req,
    pkt_pkg::core_id_t              prev
  );
    pkt_pkg::core_id_t idx;
    pkt_pkg::core_id_t pick;
    logic              found;
    pick  = prev;
    found = 1'b0;
    for (int i = 1; i <= pkt_pkg::CORE_COUNT; i++) begin
      idx = pkt_pkg::core_id_t'((int'(prev) + i) % pkt_pkg::CORE_COUNT);
      if (!found && req[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  always_comb begin
    core_out_ready = '0;
    for (int p = 0; p < pkt_pkg::PORT_COUNT; p++) begin
      core_out_ready = core_out_ready | ready_mask[p];
    end
  end

  for (genvar p = 0; p < pkt_pkg::PORT_COUNT; p++) begin : g_port
    logic [pkt_pkg::CORE_COUNT-1:0] req;
    logic [pkt_pkg::CORE_COUNT-1:0] mask;
    logic                           locked;
    logic                           active;
    pkt_pkg::core_id_t              gnt;
    pkt_pkg::core_id_t              rr_last;
    pkt_pkg::core_id_t              sel;

    // Cores with a beat bound for this port
    always_comb begin
      for (int c = 0; c < pkt_pkg::CORE_COUNT; c++) begin
        req[c] = core_out_valid[c] && (core_out_beat[c].port == pkt_pkg::port_t'(p));
      end
    end

    assign sel    = locked ? gnt : rr_pick(req, rr_last);
    assign active = locked || (req != '0);

    assign out_valid[p] = active && core_out_valid[sel];
    assign out_beat[p]  = core_out_beat[sel].beat;

    always_comb begin
      mask      = '0;
      mask[sel] = active && out_ready[p];
    end
    assign ready_mask[p] = mask;

    always_ff @(posedge clk) begin
      if (reset) begin
        locked  <= 1'b0;
        gnt     <= '0;
        rr_last <= '0;
      end else if (out_valid[p] && out_ready[p]) begin
        if (!locked) begin
          gnt     <= sel;
          rr_last <= sel;
        end
        locked <= !out_beat[p].last;
      end
    end

    // Core under grant keeps naming this port until its frame ends
    a_dest_stable: assert property (@(posedge clk) disable iff (reset)
      (locked && core_out_valid[gnt]) |-> core_out_beat[gnt].port == pkt_pkg::port_t'(p));
  end

endmodule

// File: core_slot_unit.sv
`timescale 1ns/1ps
/*
 * Store-and-forward processing core. Frames land in a ring of packet slots
 * and leave in fill order with the port swapped, as a forwarding core would.
 * slot_free pulses once per drained frame to return the dispatcher credit.
 */
module core_slot_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  pkt_pkg::routed_beat_t in_beat,
  output logic                  in_ready,
  output logic                  out_valid,
  output pkt_pkg::routed_beat_t out_beat,
  input  logic                  out_ready,
  output logic                  slot_free
);

  // Slot storage
  pkt_pkg::beat_t     mem [pkt_pkg::SLOT_COUNT][pkt_pkg::MAX_BEATS];
  pkt_pkg::beat_len_t slot_len [pkt_pkg::SLOT_COUNT];
  pkt_pkg::port_t     slot_port [pkt_pkg::SLOT_COUNT];

  // Slot holds a complete frame
  logic [pkt_pkg::SLOT_COUNT-1:0] full;

  pkt_pkg::slot_id_t  wr_slot;
  pkt_pkg::beat_idx_t wr_ptr;
  pkt_pkg::slot_id_t  rd_slot;
  pkt_pkg::beat_idx_t rd_ptr;

  logic wr_en;
  logic wr_done;
  logic rd_en;
  logic rd_end;

  function automatic pkt_pkg::slot_id_t next_slot(pkt_pkg::slot_id_t s);
    if (s == pkt_pkg::slot_id_t'(pkt_pkg::SLOT_COUNT - 1)) begin
      return '0;
    end
    return s + pkt_pkg::slot_id_t'(1);
  endfunction

  assign in_ready = !full[wr_slot];
  assign wr_en    = in_valid && in_ready;
  assign wr_done  = wr_en && in_beat.beat.last;

  // Read side
  assign out_valid     = full[rd_slot];
  assign out_beat.beat = mem[rd_slot][rd_ptr];
  assign out_beat.port = ~slot_port[rd_slot];

  assign rd_en  = out_valid && out_ready;
  assign rd_end = (pkt_pkg::beat_len_t'(rd_ptr) + pkt_pkg::beat_len_t'(1)) == slot_len[rd_slot];

  // Frame payload, length and source port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_slot][wr_ptr] <= in_beat.beat;
    end
    if (wr_done) begin
      slot_len[wr_slot]  <= pkt_pkg::beat_len_t'(wr_ptr) + pkt_pkg::beat_len_t'(1);
      slot_port[wr_slot] <= in_beat.port;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      full      <= '0;
      wr_slot   <= '0;
      wr_ptr    <= '0;
      rd_slot   <= '0;
      rd_ptr    <= '0;
      slot_free <= 1'b0;
    end else begin
      slot_free <= rd_en && rd_end;

      if (wr_en) begin
        if (in_beat.beat.last) begin
          full[wr_slot] <= 1'b1;
          wr_slot       <= next_slot(wr_slot);
          wr_ptr        <= '0;
        end else begin
          wr_ptr <= wr_ptr + pkt_pkg::beat_idx_t'(1);
        end
      end

      // Never the slot being written, that one is not full
      if (rd_en) begin
        if (rd_end) begin
          full[rd_slot] <= 1'b0;
          rd_slot       <= next_slot(rd_slot);
          rd_ptr        <= '0;
        end else begin
          rd_ptr <= rd_ptr + pkt_pkg::beat_idx_t'(1);
        end
      end
    end
  end

  // Frame length limit
  a_frame_len: assert property (@(posedge clk) disable iff (reset)
    (wr_en && wr_ptr == pkt_pkg::beat_idx_t'(pkt_pkg::MAX_BEATS - 1)) |-> in_beat.beat.last);

  // Dispatcher credit must always leave an empty slot for a new frame
  a_slot_free_at_start: assert property (@(posedge clk) disable iff (reset)
    (in_valid && wr_ptr == '0) |-> !full[wr_slot]);

endmodule

// File: pkt_dispatch.sv
`timescale 1ns/1ps
/*
 * Ingress dispatcher. Picks an ingress port round-robin at frame boundaries
 * and steers each whole frame to the lowest-index core holding a free slot.
 * Beats pass through combinationally; credits return on slot_free pulses.
 */
module pkt_dispatch (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [pkt_pkg::PORT_COUNT-1:0] in_valid,
  input  pkt_pkg::beat_t                 in_beat [pkt_pkg::PORT_COUNT],
  output logic [pkt_pkg::PORT_COUNT-1:0] in_ready,
  output logic [pkt_pkg::CORE_COUNT-1:0] core_in_valid,
  output pkt_pkg::routed_beat_t          core_in_beat,
  input  logic [pkt_pkg::CORE_COUNT-1:0] core_in_ready,
  input  logic [pkt_pkg::CORE_COUNT-1:0] slot_free
);

  // Frame lock, held from first beat to last
  logic              locked;
  pkt_pkg::port_t    lock_port;
  pkt_pkg::core_id_t lock_core;
  pkt_pkg::port_t    rr_port;

  // Free slots per core
  pkt_pkg::credit_t  credit [pkt_pkg::CORE_COUNT];

  logic                           any_credit;
  pkt_pkg::core_id_t              free_core;
  pkt_pkg::port_t                 pick_port;
  pkt_pkg::port_t                 cur_port;
  pkt_pkg::core_id_t              cur_core;
  logic                           grant_ok;
  logic                           xfer;
  logic [pkt_pkg::CORE_COUNT-1:0] take;

  // Lowest-index core with a credit wins
  always_comb begin
    any_credit = 1'b0;
    free_core  = '0;
    for (int c = pkt_pkg::CORE_COUNT - 1; c >= 0; c--) begin
      if (credit[c] != '0) begin
        any_credit = 1'b1;
        free_core  = pkt_pkg::core_id_t'(c);
      end
    end
  end

  // Favoured port first, else the other one
  assign pick_port = in_valid[rr_port] ? rr_port : ~rr_port;

  assign cur_port = locked ? lock_port : pick_port;
  assign cur_core = locked ? lock_core : free_core;

  // Nothing is granted while reset holds
  assign grant_ok = !reset && (locked || (any_credit && in_valid[pick_port]));

  assign core_in_beat.beat = in_beat[cur_port];
  assign core_in_beat.port = cur_port;

  always_comb begin
    core_in_valid           = '0;
    core_in_valid[cur_core] = grant_ok && in_valid[cur_port];
  end

  // Only the granted port ever sees ready
  always_comb begin
    in_ready           = '0;
    in_ready[cur_port] = grant_ok && core_in_ready[cur_core];
  end

  assign xfer = grant_ok && in_valid[cur_port] && core_in_ready[cur_core];

  // A credit is consumed on the first beat of a frame
  always_comb begin
    take           = '0;
    take[cur_core] = xfer && !locked;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      locked    <= 1'b0;
      lock_port <= '0;
      lock_core <= '0;
      rr_port   <= '0;
      for (int c = 0; c < pkt_pkg::CORE_COUNT; c++) begin
        credit[c] <= pkt_pkg::credit_t'(pkt_pkg::SLOT_COUNT);
      end
    end else begin
      if (xfer) begin
        if (!locked) begin
          lock_port <= cur_port;
          lock_core <= cur_core;
          rr_port   <= ~cur_port;
        end
        locked <= !core_in_beat.beat.last;
      end
      for (int c = 0; c < pkt_pkg::CORE_COUNT; c++) begin
        case ({take[c], slot_free[c]})
          2'b10:   credit[c] <= credit[c] - pkt_pkg::credit_t'(1);
          2'b01:   credit[c] <= credit[c] + pkt_pkg::credit_t'(1);
          default: credit[c] <= credit[c];
        endcase
      end
    end
  end

  for (genvar c = 0; c < pkt_pkg::CORE_COUNT; c++) begin : g_credit_chk
    // Credit stays within the slot count of the core
    a_credit_range: assert property (@(posedge clk) disable iff (reset)
      credit[c] <= pkt_pkg::SLOT_COUNT);

    // A core only releases slots it was given
    a_credit_return: assert property (@(posedge clk) disable iff (reset)
      (slot_free[c] && !take[c]) |-> credit[c] < pkt_pkg::SLOT_COUNT);
  end

endmodule

// File: pkt_pkg.sv
/*
 * Shared widths, counts and stream beat types for the packet core array.
 * Every design file refers to these by scoped name, pkt_pkg::name.
 */
package pkt_pkg;

  // Stream geometry
  localparam int DATA_WIDTH = 64;
  localparam int KEEP_WIDTH = DATA_WIDTH / 8;

  // System size
  localparam int PORT_COUNT = 2;
  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 2;
  localparam int MAX_BEATS  = 16;

  // Derived index and counter widths
  localparam int CORE_ID_WIDTH  = $clog2(CORE_COUNT);
  localparam int SLOT_ID_WIDTH  = $clog2(SLOT_COUNT);
  localparam int BEAT_IDX_WIDTH = $clog2(MAX_BEATS);
  localparam int LEN_WIDTH      = $clog2(MAX_BEATS + 1);
  localparam int CREDIT_WIDTH   = $clog2(SLOT_COUNT + 1);

  typedef logic                      port_t;
  typedef logic [CORE_ID_WIDTH-1:0]  core_id_t;
  typedef logic [SLOT_ID_WIDTH-1:0]  slot_id_t;
  typedef logic [BEAT_IDX_WIDTH-1:0] beat_idx_t;
  typedef logic [LEN_WIDTH-1:0]      beat_len_t;
  typedef logic [CREDIT_WIDTH-1:0]   credit_t;

  // One stream beat, 73 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [KEEP_WIDTH-1:0] keep;
    logic                  last;
  } beat_t;

  // Beat plus port tag: source port into a core, destination port out of it
  typedef struct packed {
    beat_t beat;
    port_t port;
  } routed_beat_t;

endpackage
